// File: hw/if_pkg.sv
/*
 * shared widths, buffer depth and select encodings of the fetch stage
 * every instruction is a 4-byte word, no compressed support
 * cnt_w must hold 0 up to fifo_depth
 */

`default_nettype none

package if_pkg;

  // data and address width
  localparam int unsigned xlen = 32;

  // prefetch buffer slots, also the number of memory credits
  localparam int unsigned fifo_depth = 3;

  // width of level, outstanding and discard counters
  localparam int unsigned cnt_w = 2;

  // low byte of the boot pc, boot base is 256-byte aligned
  localparam logic [7:0] boot_offset = 8'h80;

  // interrupt id field of the vectored mode
  localparam int unsigned irq_id_w = 5;

  ////////////////////////////////////////////////////////////////////////////
  // select encodings
  ////////////////////////////////////////////////////////////////////////////

  // next fetch pc source
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3
  } pc_sel_e;

  // trap vector source
  typedef enum logic {
    EXC_PC_EXC = 1'b0,
    EXC_PC_IRQ = 1'b1
  } exc_pc_sel_e;

  // fetch control states
  typedef enum logic [1:0] {
    FS_IDLE = 2'd0,
    FS_RUN  = 2'd1,
    FS_HOLD = 2'd2
  } fetch_state_e;

endpackage

`default_nettype wire

// File: hw/pc_select.sv
/*
 * next fetch pc mux, purely combinational
 * mtvec and boot base are taken as 256-byte aligned, low bytes are ignored
 */

`timescale 1ns/1ps
`default_nettype none

module pc_select (
  input  wire logic [if_pkg::xlen-1:0]     boot_addr_i,
  input  wire logic [if_pkg::xlen-1:0]     branch_target_i,
  input  wire logic [if_pkg::xlen-1:0]     csr_mepc_i,
  input  wire logic [if_pkg::xlen-1:0]     csr_mtvec_i,
  input  wire if_pkg::pc_sel_e             pc_mux_i,
  input  wire if_pkg::exc_pc_sel_e         exc_pc_mux_i,
  input  wire logic [if_pkg::irq_id_w-1:0] irq_id_i,
  output logic      [if_pkg::xlen-1:0]     next_pc_o
);

  logic [if_pkg::xlen-1:0] exc_base;
  logic [if_pkg::xlen-1:0] irq_offset;
  logic [if_pkg::xlen-1:0] exc_pc;
  logic [if_pkg::xlen-1:0] pc_raw;

  // trap base with the low byte forced to zero
  assign exc_base   = {csr_mtvec_i[if_pkg::xlen-1:8], 8'h00};
  // vectored mode: one word per interrupt id
  assign irq_offset = {{(if_pkg::xlen - if_pkg::irq_id_w - 2){1'b0}}, irq_id_i, 2'b00};

  always_comb begin
    unique case (exc_pc_mux_i)
      if_pkg::EXC_PC_IRQ: exc_pc = exc_base + irq_offset;
      default:            exc_pc = exc_base;
    endcase
  end

  always_comb begin
    unique case (pc_mux_i)
      if_pkg::PC_JUMP: pc_raw = branch_target_i;
      if_pkg::PC_EXC:  pc_raw = exc_pc;
      if_pkg::PC_ERET: pc_raw = csr_mepc_i;
      // boot, and any unused code, falls back to the boot pc
      default:         pc_raw = {boot_addr_i[if_pkg::xlen-1:8], if_pkg::boot_offset};
    endcase
  end

  // fetches are word aligned
  assign next_pc_o = {pc_raw[if_pkg::xlen-1:2], 2'b00};

endmodule

`default_nettype wire

// File: hw/fetch_fsm.sv
/*
 * fetch control, one request per cycle while a credit is held
 * no request goes out in the cycle of a redirect
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_fsm (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    req_i,
  input  wire logic                    pc_set_i,
  input  wire logic [if_pkg::xlen-1:0] next_pc_i,
  input  wire logic                    credit_avail_i,
  output logic                         instr_req_o,
  output logic      [if_pkg::xlen-1:0] instr_addr_o
);

  if_pkg::fetch_state_e    state_q, state_d;
  logic [if_pkg::xlen-1:0] addr_q;

  // issue only when running, holding a credit and not redirecting
  assign instr_req_o  = (state_q == if_pkg::FS_RUN) & credit_avail_i & ~pc_set_i;
  assign instr_addr_o = addr_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      // wait for the first redirect after reset
      if_pkg::FS_IDLE: if (pc_set_i) state_d = req_i ? if_pkg::FS_RUN : if_pkg::FS_HOLD;
      if_pkg::FS_RUN:  if (!req_i)   state_d = if_pkg::FS_HOLD;
      if_pkg::FS_HOLD: if (req_i)    state_d = if_pkg::FS_RUN;
      default:                       state_d = if_pkg::FS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= if_pkg::FS_IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      // redirect loads the new target, each issued word steps one word on
      if (pc_set_i) begin
        addr_q <= next_pc_i;
      end else if (instr_req_o) begin
        addr_q <= addr_q + 32'd4;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/credit_counter.sv
/*
 * credit bookkeeping for a memory that accepts every request and answers in order
 * responses to requests sent before a redirect are dropped, discards also hold a credit
 */

`timescale 1ns/1ps
`default_nettype none

module credit_counter (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     issue_i,
  input  wire logic                     rsp_valid_i,
  input  wire logic                     pc_set_i,
  input  wire logic [if_pkg::cnt_w-1:0] level_i,
  output logic                          credit_avail_o,
  output logic                          rsp_keep_o,
  output logic                          busy_o
);

  logic [if_pkg::cnt_w-1:0] outst_q, outst_d;
  logic [if_pkg::cnt_w-1:0] disc_q, disc_d;
  logic [if_pkg::cnt_w-1:0] outst_next;
  logic [if_pkg::cnt_w-1:0] disc_next;
  logic [if_pkg::cnt_w+1:0] used_slots;
  logic                     rsp_drop;

  // oldest responses belong to the discarded stream
  assign rsp_keep_o = rsp_valid_i & (disc_q == '0);
  assign rsp_drop   = rsp_valid_i & (disc_q != '0);

  // every word in flight or buffered holds one slot
  assign used_slots     = {2'b00, outst_q} + {2'b00, disc_q} + {2'b00, level_i};
  assign credit_avail_o = used_slots < if_pkg::fifo_depth;

  assign busy_o = (outst_q != '0) | (disc_q != '0);

  always_comb begin
    outst_next = outst_q + {{(if_pkg::cnt_w-1){1'b0}}, issue_i}
                         - {{(if_pkg::cnt_w-1){1'b0}}, rsp_keep_o};
    disc_next  = disc_q - {{(if_pkg::cnt_w-1){1'b0}}, rsp_drop};
    // redirect turns every pending request into a discard
    if (pc_set_i) begin
      outst_d = '0;
      disc_d  = disc_next + outst_next;
    end else begin
      outst_d = outst_next;
      disc_d  = disc_next;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outst_q <= '0;
      disc_q  <= '0;
    end else begin
      outst_q <= outst_d;
      disc_q  <= disc_d;
    end
  end

endmodule

`default_nettype wire

// File: hw/fetch_fifo.sv
/*
 * in-order prefetch buffer of fetched words and their bus error bits
 * writes beyond fifo_depth are prevented upstream by the credit scheme
 * flush wins over a write or pop in the same cycle
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_fifo (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  input  wire logic                     wr_i,
  input  wire logic [if_pkg::xlen-1:0]  wr_rdata_i,
  input  wire logic                     wr_err_i,
  input  wire logic                     flush_i,
  input  wire logic [if_pkg::xlen-1:0]  flush_pc_i,
  input  wire logic                     pop_i,
  output logic      [if_pkg::cnt_w-1:0] level_o,
  output logic                          valid_o,
  output logic      [if_pkg::xlen-1:0]  rdata_o,
  output logic                          err_o,
  output logic      [if_pkg::xlen-1:0]  pc_o
);

  logic [if_pkg::xlen-1:0]  data_q [if_pkg::fifo_depth];
  logic                     err_q  [if_pkg::fifo_depth];
  logic [if_pkg::cnt_w-1:0] rd_ptr_q;
  logic [if_pkg::cnt_w-1:0] wr_ptr_q;
  logic [if_pkg::cnt_w-1:0] level_q;
  logic [if_pkg::xlen-1:0]  pc_q;

  // circular pointer step
  function automatic logic [if_pkg::cnt_w-1:0] ptr_inc(input logic [if_pkg::cnt_w-1:0] ptr);
    if (ptr == if_pkg::cnt_w'(if_pkg::fifo_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // head entry drives the outputs
  assign level_o = level_q;
  assign valid_o = level_q != '0;
  assign rdata_o = data_q[rd_ptr_q];
  assign err_o   = err_q[rd_ptr_q];
  assign pc_o    = pc_q;

  // storage, written at the tail
  always_ff @(posedge clk_i) begin
    if (wr_i) begin
      data_q[wr_ptr_q] <= wr_rdata_i;
      err_q[wr_ptr_q]  <= wr_err_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      level_q  <= '0;
      pc_q     <= '0;
    end else if (flush_i) begin
      // empty in one edge, head pc restarts at the redirect target
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      level_q  <= '0;
      pc_q     <= flush_pc_i;
    end else begin
      if (wr_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
        pc_q     <= pc_q + 32'd4;
      end
      if (wr_i && !pop_i) begin
        level_q <= level_q + 1'b1;
      end else if (pop_i && !wr_i) begin
        level_q <= level_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/if_id_reg.sv
/*
 * IF-ID pipeline register with valid/new tracking
 * a word taken in the cycle of a redirect is dropped, not loaded
 * mismatch alarm checks strict +4 steps between redirects
 */

`timescale 1ns/1ps
`default_nettype none

module if_id_reg (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  input  wire logic                    if_valid_i,
  input  wire logic [if_pkg::xlen-1:0] if_rdata_i,
  input  wire logic                    if_err_i,
  input  wire logic [if_pkg::xlen-1:0] if_pc_i,
  input  wire logic                    id_in_ready_i,
  input  wire logic                    pc_set_i,
  input  wire logic                    instr_valid_clear_i,
  output logic                         pop_o,
  output logic                         instr_valid_id_o,
  output logic                         instr_new_id_o,
  output logic      [if_pkg::xlen-1:0] instr_rdata_id_o,
  output logic                         instr_fetch_err_o,
  output logic      [if_pkg::xlen-1:0] pc_id_o,
  output logic                         pc_mismatch_alert_o
);

  logic accept;
  logic load;
  logic valid_q;
  logic new_q;
  logic seq_q;

  // handshake with the buffer head
  assign accept = if_valid_i & id_in_ready_i;
  assign pop_o  = accept;
  // the old stream never reaches ID once a redirect is seen
  assign load   = accept & ~pc_set_i;

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

  // alarm if a sequential fetch does not follow the previous pc by one word
  assign pc_mismatch_alert_o = seq_q & accept & (if_pc_i != pc_id_o + 32'd4);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
      seq_q   <= 1'b0;
    end else begin
      // valid holds until ID clears it
      valid_q <= load | (valid_q & ~instr_valid_clear_i);
      new_q   <= load;
      seq_q   <= (seq_q | accept) & ~pc_set_i;
    end
  end

  // payload, frozen while ID stalls
  always_ff @(posedge clk_i) begin
    if (load) begin
      instr_rdata_id_o  <= if_rdata_i;
      instr_fetch_err_o <= if_err_i;
      pc_id_o           <= if_pc_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/if_stage.sv
/*
 * instruction fetch stage top, credit-based memory side without grant
 * memory must answer every request once, in order, at least one cycle later
 */

`timescale 1ns/1ps
`default_nettype none

module if_stage (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  input  wire logic                        req_i,
  input  wire logic                        pc_set_i,
  input  wire if_pkg::pc_sel_e             pc_mux_i,
  input  wire if_pkg::exc_pc_sel_e         exc_pc_mux_i,
  input  wire logic [if_pkg::irq_id_w-1:0] exc_irq_id_i,
  input  wire logic [if_pkg::xlen-1:0]     boot_addr_i,
  input  wire logic [if_pkg::xlen-1:0]     branch_target_i,
  input  wire logic [if_pkg::xlen-1:0]     csr_mepc_i,
  input  wire logic [if_pkg::xlen-1:0]     csr_mtvec_i,
  output logic                             instr_req_o,
  output logic      [if_pkg::xlen-1:0]     instr_addr_o,
  input  wire logic                        instr_rvalid_i,
  input  wire logic [if_pkg::xlen-1:0]     instr_rdata_i,
  input  wire logic                        instr_err_i,
  input  wire logic                        id_in_ready_i,
  input  wire logic                        instr_valid_clear_i,
  output logic                             instr_valid_id_o,
  output logic                             instr_new_id_o,
  output logic      [if_pkg::xlen-1:0]     instr_rdata_id_o,
  output logic                             instr_fetch_err_o,
  output logic      [if_pkg::xlen-1:0]     pc_id_o,
  output logic                             pc_mismatch_alert_o,
  output logic                             if_busy_o
);

  logic [if_pkg::xlen-1:0]  next_pc;
  logic                     credit_avail;
  logic                     rsp_keep;
  logic [if_pkg::cnt_w-1:0] level;
  logic                     if_valid;
  logic [if_pkg::xlen-1:0]  if_rdata;
  logic                     if_err;
  logic [if_pkg::xlen-1:0]  if_pc;
  logic                     fifo_pop;

  ////////////////////////////////////////////////////////////////////////////
  // pc selection and request side
  ////////////////////////////////////////////////////////////////////////////

  pc_select u_pc_select (
    .boot_addr_i     (boot_addr_i),
    .branch_target_i (branch_target_i),
    .csr_mepc_i      (csr_mepc_i),
    .csr_mtvec_i     (csr_mtvec_i),
    .pc_mux_i        (pc_mux_i),
    .exc_pc_mux_i    (exc_pc_mux_i),
    .irq_id_i        (exc_irq_id_i),
    .next_pc_o       (next_pc)
  );

  fetch_fsm u_fetch_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .pc_set_i       (pc_set_i),
    .next_pc_i      (next_pc),
    .credit_avail_i (credit_avail),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o)
  );

  // request output doubles as the issue strobe
  credit_counter u_credit_counter (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .issue_i        (instr_req_o),
    .rsp_valid_i    (instr_rvalid_i),
    .pc_set_i       (pc_set_i),
    .level_i        (level),
    .credit_avail_o (credit_avail),
    .rsp_keep_o     (rsp_keep),
    .busy_o         (if_busy_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // response side, buffer and IF-ID register
  ////////////////////////////////////////////////////////////////////////////

  fetch_fifo u_fetch_fifo (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr_i       (rsp_keep),
    .wr_rdata_i (instr_rdata_i),
    .wr_err_i   (instr_err_i),
    .flush_i    (pc_set_i),
    .flush_pc_i (next_pc),
    .pop_i      (fifo_pop),
    .level_o    (level),
    .valid_o    (if_valid),
    .rdata_o    (if_rdata),
    .err_o      (if_err),
    .pc_o       (if_pc)
  );

  if_id_reg u_if_id_reg (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .if_valid_i          (if_valid),
    .if_rdata_i          (if_rdata),
    .if_err_i            (if_err),
    .if_pc_i             (if_pc),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .pop_o               (fifo_pop),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_id_o             (pc_id_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

endmodule

`default_nettype wire

// File: dv/tb_if_stage.sv
/*
 * testbench of the fetch stage, random memory latency, stalls and redirects
 * checks run at the falling edge, inputs change 10 ns after the rising edge
 */

`timescale 1ns/1ps
`default_nettype none

module tb_if_stage;

  localparam int n_redirects = 12;
  localparam int long_goal   = 6;
  localparam int short_goal  = 2;
  localparam int n_instr     = (n_redirects / 2) * (long_goal + short_goal);
  // 20 cycles per redirect plus 10 per instruction, doubled as margin
  localparam int wd_cycles   = 2 * (20 * n_redirects + 10 * n_instr);

  logic clk_i, rst_ni, req_i, pc_set_i;
  if_pkg::pc_sel_e     pc_mux_i;
  if_pkg::exc_pc_sel_e exc_pc_mux_i;
  logic [4:0]  exc_irq_id_i;
  logic [31:0] boot_addr_i, branch_target_i, csr_mepc_i, csr_mtvec_i;
  logic        instr_req_o, instr_rvalid_i, instr_err_i;
  logic [31:0] instr_addr_o, instr_rdata_i;
  logic        id_in_ready_i, instr_valid_clear_i;
  logic        instr_valid_id_o, instr_new_id_o, instr_fetch_err_o;
  logic [31:0] instr_rdata_id_o, pc_id_o;
  logic        pc_mismatch_alert_o, if_busy_o;

  if_stage uut (.*);

  logic [31:0] lfsr = 32'hd367_f3bb;
  int          cyc = 0;
  int          epoch = 0;
  int          rsp_epoch;
  int          held = 0;
  int          delivered = 0;
  int          lat_next = 1;
  int          stall_left = 0;
  bit          started = 0;
  logic [31:0] exp_addr, exp_id_pc;
  logic        exp_busy;
  logic [31:0] mem_addr [$];
  int          mem_due [$];
  int          mem_epoch [$];
  logic        prev_valid = 0, prev_clear = 0, prev_set = 0;
  logic [31:0] prev_rdata, prev_pc;
  logic        prev_err;

  // galois lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic fail_msg(input string what);
    $display("failure at %0t ns: %s", $time, what);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  // redirect target as the fetch rules define it
  function automatic logic [31:0] target_pc();
    logic [31:0] vec;
    vec = {csr_mtvec_i[31:8], 8'h00};
    case (pc_mux_i)
      if_pkg::PC_JUMP: return branch_target_i & ~32'h3;
      if_pkg::PC_ERET: return csr_mepc_i & ~32'h3;
      if_pkg::PC_EXC: begin
        if (exc_pc_mux_i == if_pkg::EXC_PC_IRQ) begin
          return vec + {exc_irq_id_i, 2'b00};
        end
        return vec;
      end
      default:         return {boot_addr_i[31:8], 8'h80};
    endcase
  endfunction

  initial begin
    clk_i = 0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cyc <= cyc + 1;

  // one cycle of stimulus, memory response first
  task automatic drive_cycle(input logic redirect);
    logic [31:0] r;
    int          src;
    @(posedge clk_i);
    #10;
    instr_rvalid_i = 1'b0;
    if (mem_addr.size() > 0 && mem_due[0] <= cyc) begin
      instr_rvalid_i = 1'b1;
      instr_rdata_i  = mem_addr[0] ^ 32'h5a5a_0000;
      instr_err_i    = mem_addr[0][6];
      rsp_epoch      = mem_epoch[0];
      void'(mem_addr.pop_front());
      void'(mem_due.pop_front());
      void'(mem_epoch.pop_front());
    end
    r = take_bits(2);
    lat_next = (r % 3) + 1;
    r = take_bits(2);
    id_in_ready_i = (stall_left > 0) ? 1'b0 : (r != 0);
    if (stall_left > 0) stall_left--;
    r = take_bits(3);
    req_i = (r != 0);
    r = take_bits(2);
    instr_valid_clear_i = (r == 0);
    pc_set_i = redirect;
    if (redirect) begin
      r = take_bits(3);
      // the first five redirects walk through every source once
      src = (epoch < 5) ? epoch : int'(r % 5);
      // 0 boot, 1 jump, 2 exception, 3 interrupt, 4 eret
      pc_mux_i     = (src == 0) ? if_pkg::PC_BOOT : (src == 1) ? if_pkg::PC_JUMP :
                     (src <= 3) ? if_pkg::PC_EXC : if_pkg::PC_ERET;
      exc_pc_mux_i = (src == 3) ? if_pkg::EXC_PC_IRQ : if_pkg::EXC_PC_EXC;
      r = take_bits(5);
      exc_irq_id_i = r[4:0];
      boot_addr_i     = take_bits(32);
      branch_target_i = take_bits(32);
      csr_mepc_i      = take_bits(32);
      csr_mtvec_i     = take_bits(32);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checks and reference bookkeeping
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (!started) begin
        assert (!instr_req_o && !instr_valid_id_o && !instr_new_id_o && !if_busy_o)
          else fail_msg("stage active before the first redirect");
      end
      assert (!pc_mismatch_alert_o) else fail_msg("pc mismatch alarm raised");
      // busy while the memory still owes a response, the one on the bus included
      exp_busy = (mem_addr.size() != 0) || instr_rvalid_i;
      assert (if_busy_o == exp_busy) else fail_value("if_busy_o", exp_busy, if_busy_o);
      if (instr_new_id_o) begin
        assert (instr_valid_id_o) else fail_msg("new instruction without valid");
        assert (pc_id_o == exp_id_pc) else fail_value("pc_id_o", exp_id_pc, pc_id_o);
        assert (instr_rdata_id_o == (exp_id_pc ^ 32'h5a5a_0000))
          else fail_value("instr_rdata_id_o", exp_id_pc ^ 32'h5a5a_0000, instr_rdata_id_o);
        assert (instr_fetch_err_o == exp_id_pc[6])
          else fail_value("instr_fetch_err_o", exp_id_pc[6], instr_fetch_err_o);
        exp_id_pc = exp_id_pc + 32'd4;
        delivered++;
        held--;
      end else if (prev_valid && instr_valid_id_o) begin
        // stalled ID register must not move
        assert (pc_id_o == prev_pc) else fail_value("pc_id_o", prev_pc, pc_id_o);
        assert (instr_rdata_id_o == prev_rdata)
          else fail_value("instr_rdata_id_o", prev_rdata, instr_rdata_id_o);
        assert (instr_fetch_err_o == prev_err)
          else fail_value("instr_fetch_err_o", prev_err, instr_fetch_err_o);
      end
      if (prev_valid && !instr_valid_id_o) begin
        assert (prev_clear || prev_set) else fail_msg("valid dropped without clear");
      end
      if (instr_rvalid_i && rsp_epoch == epoch) held++;
      if (pc_set_i) begin
        assert (!instr_req_o) else fail_msg("request issued in the redirect cycle");
        exp_addr  = target_pc();
        exp_id_pc = exp_addr;
        held      = 0;
        epoch++;
        started   = 1;
      end else if (instr_req_o) begin
        assert (instr_addr_o == exp_addr) else fail_value("instr_addr_o", exp_addr, instr_addr_o);
        mem_addr.push_back(instr_addr_o);
        mem_due.push_back(cyc + lat_next);
        mem_epoch.push_back(epoch);
        exp_addr = exp_addr + 32'd4;
      end
      // words in flight plus buffered kept words share three slots
      assert (held >= 0 && mem_addr.size() + held <= if_pkg::fifo_depth)
        else fail_msg("credit limit exceeded");
      prev_valid = instr_valid_id_o;
      prev_clear = instr_valid_clear_i;
      prev_set   = pc_set_i;
      prev_rdata = instr_rdata_id_o;
      prev_pc    = pc_id_o;
      prev_err   = instr_fetch_err_o;
    end
  end

  initial begin
    #(wd_cycles * 100);
    $display("watchdog expired, delivery stalled");
    $display("STATUS: FAIL");
    $fatal(1);
  end

  initial begin
    int goal;
    int base;
    rst_ni = 0;
    req_i = 0;
    pc_set_i = 0;
    pc_mux_i = if_pkg::PC_BOOT;
    exc_pc_mux_i = if_pkg::EXC_PC_EXC;
    exc_irq_id_i = '0;
    boot_addr_i = '0;
    branch_target_i = '0;
    csr_mepc_i = '0;
    csr_mtvec_i = '0;
    instr_rvalid_i = 0;
    instr_rdata_i = '0;
    instr_err_i = 0;
    id_in_ready_i = 0;
    instr_valid_clear_i = 0;
    repeat (3) @(posedge clk_i);
    #10 rst_ni = 1;
    // a few idle cycles to check the reset state
    repeat (4) drive_cycle(1'b0);
    for (int ep = 0; ep < n_redirects; ep++) begin
      // odd epochs redirect early to squash words in flight
      goal = (ep % 2) ? short_goal : long_goal;
      drive_cycle(1'b1);
      if (ep == 3 || ep == 8) stall_left = 20;
      base = delivered;
      while (delivered - base < goal) drive_cycle(1'b0);
    end
    repeat (5) drive_cycle(1'b0);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
hw/if_pkg.sv
hw/pc_select.sv
hw/fetch_fsm.sv
hw/credit_counter.sv
hw/fetch_fifo.sv
hw/if_id_reg.sv
hw/if_stage.sv
dv/tb_if_stage.sv

// File: run.sh
#!/bin/sh
# compile and run the fetch stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_if_stage -f sources.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "compile failed, see build.log"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?

if grep -q "STATUS: FAIL" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
if [ $run_status -ne 0 ] || ! grep -q "STATUS: PASS" sim.log; then
  echo "simulation did not complete, see sim.log"
  exit 1
fi
echo "simulation passed"
exit 0
